/* include/video_macros.svh */
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// raster geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define H_ACTIVE      32
`define V_ACTIVE      24
`define H_TOTAL       40
`define V_TOTAL       28

// sync pulses, end is exclusive
`define H_SYNC_START  34
`define H_SYNC_END    38
`define V_SYNC_START  25
`define V_SYNC_END    27

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sprites and pipeline
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CAR_SIZE      4
// coordinate to RGB pin, in clocks
`define PIXEL_LATENCY 3

`endif

/* design/video_pkg.sv */
package video_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // raster and color types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // wide enough for h up to 39 and car positions up to 63
    typedef logic [5:0] coord_t;

    // 8:8:8, red in the top byte
    typedef logic [23:0] rgb_t;

    typedef logic [15:0] frame_count_t;

    // checker colors of the track
    localparam rgb_t TRACK_DARK  = 24'h204020;
    localparam rgb_t TRACK_LIGHT = 24'h304830;

endpackage

/* design/sprite_pkg.sv */
package sprite_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sprite buffer types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [0:0] {
        CAR1 = 1'b0,
        CAR2 = 1'b1
    } car_id_t;

    // clockwise quarter turns
    typedef logic [1:0] angle_t;

    // 4:4:4 color, red nibble on top
    typedef logic [11:0] sprite_word_t;

    // {car, row[1:0], col[1:0]}
    typedef logic [4:0] sprite_addr_t;

    // bit row*4 + col is set when the pixel is opaque
    typedef logic [15:0] mask_t;

    typedef logic [3:0] mask_index_t;

endpackage

/* design/sprite_bus_if.sv */
`timescale 1ns/1ns

// one port of the sprite buffer
interface sprite_bus_if;
    import sprite_pkg::*;

    sprite_addr_t addr;
    sprite_word_t wdata;
    logic         we;
    logic         re;
    sprite_word_t rdata;

    modport writer (output addr, output wdata, output we);
    modport reader (output addr, output re, input rdata);
    modport buffer (input addr, input wdata, input we, input re, output rdata);
endinterface

// opacity stream from the encoder, one mask bit per strobe
interface mask_wr_if;
    import sprite_pkg::*;

    logic        we;
    car_id_t     car;
    mask_index_t index;
    logic        opaque;

    modport sender (output we, output car, output index, output opaque);
    modport receiver (input we, input car, input index, input opaque);
endinterface

/* design/vga_timing.sv */
`timescale 1ns/1ns
`include "video_macros.svh"

module vga_timing (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  video_pkg::rgb_t         i_color,
    output video_pkg::coord_t       o_h,
    output video_pkg::coord_t       o_v,
    output logic                    o_active,
    output logic                    o_frame_start,
    output logic                    o_hsync_n,
    output logic                    o_vsync_n,
    output video_pkg::rgb_t         o_rgb,
    output logic                    o_rgb_valid,
    output video_pkg::frame_count_t o_frame_count
);
    import video_pkg::*;

    localparam int LAT = `PIXEL_LATENCY;

    coord_t       h_q;
    coord_t       v_q;
    logic         hsync_n;
    logic         vsync_n;
    logic [LAT-1:0] active_sr;
    logic [LAT-1:0] hsync_sr;
    logic [LAT-1:0] vsync_sr;
    rgb_t         rgb_q;
    frame_count_t frame_cnt_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // raster counters
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            h_q <= '0;
            v_q <= '0;
        end else if (h_q == coord_t'(`H_TOTAL - 1)) begin
            h_q <= '0;
            if (v_q == coord_t'(`V_TOTAL - 1)) begin
                v_q <= '0;
            end else begin
                v_q <= v_q + 1'b1;
            end
        end else begin
            h_q <= h_q + 1'b1;
        end
    end

    assign o_h = h_q;
    assign o_v = v_q;
    assign o_active = (h_q < coord_t'(`H_ACTIVE)) && (v_q < coord_t'(`V_ACTIVE));
    // first cycle of vertical blank
    assign o_frame_start = (h_q == '0) && (v_q == coord_t'(`V_ACTIVE));

    assign hsync_n = !((h_q >= coord_t'(`H_SYNC_START)) && (h_q < coord_t'(`H_SYNC_END)));
    assign vsync_n = !((v_q >= coord_t'(`V_SYNC_START)) && (v_q < coord_t'(`V_SYNC_END)));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output alignment
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // levels travel alongside the composer pipeline, color gets the last stage here
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            active_sr   <= '0;
            hsync_sr    <= '1;
            vsync_sr    <= '1;
            rgb_q       <= '0;
            frame_cnt_q <= '0;
        end else begin
            active_sr <= {active_sr[LAT-2:0], o_active};
            hsync_sr  <= {hsync_sr[LAT-2:0], hsync_n};
            vsync_sr  <= {vsync_sr[LAT-2:0], vsync_n};
            rgb_q     <= i_color;
            if (o_frame_start) begin
                frame_cnt_q <= frame_cnt_q + 16'd1;
            end
        end
    end

    assign o_rgb_valid   = active_sr[LAT-1];
    assign o_hsync_n     = hsync_sr[LAT-1];
    assign o_vsync_n     = vsync_sr[LAT-1];
    assign o_rgb         = rgb_q;
    assign o_frame_count = frame_cnt_q;

    // sync pulses live entirely in blanking
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_rgb_valid |-> (o_hsync_n && o_vsync_n));

endmodule

/* design/sprite_encoder.sv */
`timescale 1ns/1ns
`include "video_macros.svh"

module sprite_encoder (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_frame_start,
    input  sprite_pkg::angle_t  i_car1_angle,
    input  sprite_pkg::angle_t  i_car2_angle,
    sprite_bus_if.writer        bus,
    mask_wr_if.sender           mask,
    output logic                o_busy
);
    import sprite_pkg::*;

    // both cars, one word per destination pixel
    localparam int WORDS = 2 * `CAR_SIZE * `CAR_SIZE;

    angle_t       car1_angle_q;
    angle_t       car2_angle_q;
    sprite_addr_t cnt_q;
    logic         busy_q;

    car_id_t      car;
    angle_t       angle;
    logic [1:0]   dst_row;
    logic [1:0]   dst_col;
    logic [1:0]   src_row;
    logic [1:0]   src_col;
    logic [3:0]   red;
    sprite_word_t src_color;
    logic         src_opaque;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sequencer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy_q       <= 1'b0;
            cnt_q        <= '0;
            car1_angle_q <= '0;
            car2_angle_q <= '0;
        end else if (i_frame_start) begin
            busy_q       <= 1'b1;
            cnt_q        <= '0;
            car1_angle_q <= i_car1_angle;
            car2_angle_q <= i_car2_angle;
        end else if (busy_q) begin
            if (cnt_q == sprite_addr_t'(WORDS - 1)) begin
                busy_q <= 1'b0;
            end
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // counter doubles as the buffer address
    assign car     = car_id_t'(cnt_q[4]);
    assign dst_row = cnt_q[3:2];
    assign dst_col = cnt_q[1:0];
    assign angle   = (car == CAR2) ? car2_angle_q : car1_angle_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // rotation and sprite ROM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // source pixel for each destination pixel
    always_comb begin
        case (angle)
            2'd0: begin
                src_row = dst_row;
                src_col = dst_col;
            end
            2'd1: begin
                src_row = 2'd3 - dst_col;
                src_col = dst_row;
            end
            2'd2: begin
                src_row = 2'd3 - dst_row;
                src_col = 2'd3 - dst_col;
            end
            default: begin
                src_row = dst_col;
                src_col = 2'd3 - dst_row;
            end
        endcase
    end

    // car1 is bright red, car2 dim red; row and column shade green and blue
    assign red        = (car == CAR1) ? 4'hF : 4'h3;
    assign src_color  = {red, src_row, 2'b00, src_col, 2'b00};
    // two front corners are cut out
    assign src_opaque = !((src_row == 2'd0) && ((src_col == 2'd0) || (src_col == 2'd3)));

    assign bus.addr  = cnt_q;
    assign bus.wdata = src_color;
    assign bus.we    = busy_q;

    assign mask.we     = busy_q;
    assign mask.car    = car;
    assign mask.index  = cnt_q[3:0];
    assign mask.opaque = src_opaque;

    assign o_busy = busy_q;

    // rendering must finish inside one blanking interval
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_frame_start |-> !o_busy);

endmodule

/* design/opacity_mask.sv */
`timescale 1ns/1ns
`include "video_macros.svh"

module opacity_mask (
    input  logic                i_clk,
    input  logic                i_rst_n,
    mask_wr_if.receiver         mask,
    output sprite_pkg::mask_t   o_car1_mask,
    output sprite_pkg::mask_t   o_car2_mask
);
    import sprite_pkg::*;

    localparam int BITS = `CAR_SIZE * `CAR_SIZE;

    mask_t car1_q;
    mask_t car2_q;

    // masks hold between frames, only addressed bits change
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            car1_q <= '0;
            car2_q <= '0;
        end else if (mask.we) begin
            for (int i = 0; i < BITS; i++) begin
                if (mask.index == mask_index_t'(i)) begin
                    if (mask.car == CAR1) begin
                        car1_q[i] <= mask.opaque;
                    end else begin
                        car2_q[i] <= mask.opaque;
                    end
                end
            end
        end
    end

    assign o_car1_mask = car1_q;
    assign o_car2_mask = car2_q;

endmodule

/* design/frame_composer.sv */
`timescale 1ns/1ns
`include "video_macros.svh"

module frame_composer (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_frame_start,
    input  video_pkg::coord_t   i_h,
    input  video_pkg::coord_t   i_v,
    input  logic                i_active,
    input  video_pkg::coord_t   i_car1_x,
    input  video_pkg::coord_t   i_car1_y,
    input  video_pkg::coord_t   i_car2_x,
    input  video_pkg::coord_t   i_car2_y,
    input  sprite_pkg::mask_t   i_car1_mask,
    input  sprite_pkg::mask_t   i_car2_mask,
    sprite_bus_if.reader        bus,
    output video_pkg::rgb_t     o_color
);
    import video_pkg::*;
    import sprite_pkg::*;

    coord_t car1_x_q;
    coord_t car1_y_q;
    coord_t car2_x_q;
    coord_t car2_y_q;

    coord_t dx1;
    coord_t dy1;
    coord_t dx2;
    coord_t dy2;
    logic   hit1;
    logic   hit2;

    logic   hit_q;
    logic   active_q;
    logic   odd_q;
    rgb_t   color_q;

    // positions only move at the start of blanking
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            car1_x_q <= '0;
            car1_y_q <= '0;
            car2_x_q <= '0;
            car2_y_q <= '0;
        end else if (i_frame_start) begin
            car1_x_q <= i_car1_x;
            car1_y_q <= i_car1_y;
            car2_x_q <= i_car2_x;
            car2_y_q <= i_car2_y;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage 1: hit test and read
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // offsets wrap, so pixels left of or above a car fall far outside the box
    assign dx1 = i_h - car1_x_q;
    assign dy1 = i_v - car1_y_q;
    assign dx2 = i_h - car2_x_q;
    assign dy2 = i_v - car2_y_q;

    assign hit1 = (dx1 < coord_t'(`CAR_SIZE)) && (dy1 < coord_t'(`CAR_SIZE))
                  && i_car1_mask[{dy1[1:0], dx1[1:0]}];
    assign hit2 = (dx2 < coord_t'(`CAR_SIZE)) && (dy2 < coord_t'(`CAR_SIZE))
                  && i_car2_mask[{dy2[1:0], dx2[1:0]}];

    // car2 is drawn on top
    assign bus.addr = hit2 ? {CAR2, dy2[1:0], dx2[1:0]} : {CAR1, dy1[1:0], dx1[1:0]};
    assign bus.re   = i_active && (hit1 || hit2);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            hit_q    <= 1'b0;
            active_q <= 1'b0;
            odd_q    <= 1'b0;
        end else begin
            hit_q    <= bus.re;
            active_q <= i_active;
            // parity of h/4 + v/4
            odd_q    <= i_h[2] ^ i_v[2];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage 2: color select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            color_q <= '0;
        end else if (!active_q) begin
            color_q <= '0;
        end else if (hit_q) begin
            // 4:4:4 to 8:8:8 by nibble repeat
            color_q <= {bus.rdata[11:8], bus.rdata[11:8],
                        bus.rdata[7:4],  bus.rdata[7:4],
                        bus.rdata[3:0],  bus.rdata[3:0]};
        end else begin
            color_q <= odd_q ? TRACK_LIGHT : TRACK_DARK;
        end
    end

    assign o_color = color_q;

endmodule

/* design/sprite_buffer.sv */
`timescale 1ns/1ns

module sprite_buffer (
    input  logic            i_clk,
    sprite_bus_if.buffer    wr,
    sprite_bus_if.buffer    rd
);
    import sprite_pkg::*;

    localparam int DEPTH = 2 ** $bits(sprite_addr_t);

    sprite_word_t mem [0:DEPTH-1];
    sprite_word_t rdata_q;
    sprite_addr_t addr;

    // single physical port owned by the writer whenever it strobes
    assign addr = wr.we ? wr.addr : rd.addr;

    always_ff @(posedge i_clk) begin
        if (wr.we) begin
            mem[addr] <= wr.wdata;
        end else if (rd.re) begin
            rdata_q <= mem[addr];
        end
    end

    assign rd.rdata = rdata_q;

    // encoder runs in blanking while the composer reads only in active video
    assert property (@(posedge i_clk) !(wr.we && rd.re));

endmodule

/* design/race_display.sv */
`timescale 1ns/1ns

module race_display (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  video_pkg::coord_t       i_car1_x,
    input  video_pkg::coord_t       i_car1_y,
    input  video_pkg::coord_t       i_car2_x,
    input  video_pkg::coord_t       i_car2_y,
    input  sprite_pkg::angle_t      i_car1_angle,
    input  sprite_pkg::angle_t      i_car2_angle,
    output logic                    o_hsync_n,
    output logic                    o_vsync_n,
    output video_pkg::rgb_t         o_rgb,
    output logic                    o_rgb_valid,
    output video_pkg::frame_count_t o_frame_count
);
    import video_pkg::*;
    import sprite_pkg::*;

    coord_t h;
    coord_t v;
    logic   active;
    logic   frame_start;
    rgb_t   color;
    mask_t  car1_mask;
    mask_t  car2_mask;

    sprite_bus_if wr_bus ();
    sprite_bus_if rd_bus ();
    mask_wr_if    mask_bus ();

    vga_timing u_vga_timing (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_color        (color),
        .o_h            (h),
        .o_v            (v),
        .o_active       (active),
        .o_frame_start  (frame_start),
        .o_hsync_n      (o_hsync_n),
        .o_vsync_n      (o_vsync_n),
        .o_rgb          (o_rgb),
        .o_rgb_valid    (o_rgb_valid),
        .o_frame_count  (o_frame_count)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // blanking side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    sprite_encoder u_sprite_encoder (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_frame_start  (frame_start),
        .i_car1_angle   (i_car1_angle),
        .i_car2_angle   (i_car2_angle),
        .bus            (wr_bus),
        .mask           (mask_bus),
        .o_busy         ()
    );

    opacity_mask u_opacity_mask (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .mask           (mask_bus),
        .o_car1_mask    (car1_mask),
        .o_car2_mask    (car2_mask)
    );

    sprite_buffer u_sprite_buffer (
        .i_clk          (i_clk),
        .wr             (wr_bus),
        .rd             (rd_bus)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // active video side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    frame_composer u_frame_composer (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_frame_start  (frame_start),
        .i_h            (h),
        .i_v            (v),
        .i_active       (active),
        .i_car1_x       (i_car1_x),
        .i_car1_y       (i_car1_y),
        .i_car2_x       (i_car2_x),
        .i_car2_y       (i_car2_y),
        .i_car1_mask    (car1_mask),
        .i_car2_mask    (car2_mask),
        .bus            (rd_bus),
        .o_color        (color)
    );

endmodule

/* dv/tb_clock.sv */
`timescale 1ns/1ns

// free running clock and a power-on reset
module tb_clock #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 10
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_rst_n <= 1'b1;
    end

endmodule

/* dv/tb_race_display.sv */
`timescale 1ns/1ns
`include "video_macros.svh"

module tb_race_display;
    import video_pkg::*;
    import sprite_pkg::*;

    localparam int FRAME_PIXELS = `H_ACTIVE * `V_ACTIVE;
    // the tests need about 27 frames
    localparam int TIMEOUT_CYCLES = 30 * `H_TOTAL * `V_TOTAL;
    localparam rgb_t BG_EVEN = 24'h204020;
    localparam rgb_t BG_ODD  = 24'h304830;

    logic         clk;
    logic         rst_n;
    coord_t       car1_x;
    coord_t       car1_y;
    coord_t       car2_x;
    coord_t       car2_y;
    angle_t       car1_angle;
    angle_t       car2_angle;
    logic         hsync_n;
    logic         vsync_n;
    rgb_t         rgb;
    logic         rgb_valid;
    frame_count_t frame_count;

    int           error_count;
    int           check_total;
    int           cycle_count;
    int           pix_count;
    rgb_t         frame_pix [0:FRAME_PIXELS-1];
    logic [31:0]  rng_state;
    coord_t       next_pos [0:3];
    angle_t       next_angle [0:1];

    tb_clock u_clock (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    race_display i_dut (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_car1_x      (car1_x),
        .i_car1_y      (car1_y),
        .i_car2_x      (car2_x),
        .i_car2_y      (car2_y),
        .i_car1_angle  (car1_angle),
        .i_car2_angle  (car2_angle),
        .o_hsync_n     (hsync_n),
        .o_vsync_n     (vsync_n),
        .o_rgb         (rgb),
        .o_rgb_valid   (rgb_valid),
        .o_frame_count (frame_count)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_rgb(input string name, input rgb_t actual, input rgb_t expected);
        check_total++;
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_frame_count(input string name, input frame_count_t actual,
                                     input frame_count_t expected);
        check_total++;
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_level(input string name, input logic actual, input logic expected);
        check_total++;
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
            error_count++;
        end
    endtask

    task automatic expect_count(input string name, input int actual, input int expected);
        check_total++;
        if (actual != expected) begin
            $display("CHECK FAILED %s: got %0h, expected %0h", name, actual, expected);
            error_count++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one car at a screen pixel, returns 1 with its color when opaque
    function automatic logic car_pixel(input int h, input int v, input coord_t x,
                                       input coord_t y, input angle_t angle,
                                       input logic [3:0] red, output rgb_t color);
        int r;
        int c;
        int sr;
        int sc;
        logic [3:0] g;
        logic [3:0] b;
        color = '0;
        r = v - int'(y);
        c = h - int'(x);
        if (r < 0 || r > 3 || c < 0 || c > 3) begin
            return 1'b0;
        end
        case (angle)
            2'd0: begin
                sr = r;
                sc = c;
            end
            2'd1: begin
                sr = 3 - c;
                sc = r;
            end
            2'd2: begin
                sr = 3 - r;
                sc = 3 - c;
            end
            default: begin
                sr = c;
                sc = 3 - r;
            end
        endcase
        if (sr == 0 && (sc == 0 || sc == 3)) begin
            return 1'b0;
        end
        g = 4'(sr * 4);
        b = 4'(sc * 4);
        color = {red, red, g, g, b, b};
        return 1'b1;
    endfunction

    function automatic rgb_t expected_pixel(input int h, input int v,
                                            input coord_t x1, input coord_t y1,
                                            input angle_t a1, input coord_t x2,
                                            input coord_t y2, input angle_t a2);
        rgb_t color;
        // car2 on top
        if (car_pixel(h, v, x2, y2, a2, 4'h3, color)) begin
            return color;
        end
        if (car_pixel(h, v, x1, y1, a1, 4'hF, color)) begin
            return color;
        end
        if (((h / 4) + (v / 4)) % 2 == 0) begin
            return BG_EVEN;
        end
        return BG_ODD;
    endfunction

    function automatic logic [31:0] random_word();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic rgb_t pixel_at(input int h, input int v);
        return frame_pix[v * `H_ACTIVE + h];
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // drivers and monitor
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic drive_cars(input coord_t x1, input coord_t y1, input angle_t a1,
                              input coord_t x2, input coord_t y2, input angle_t a2);
        @(posedge clk);
        car1_x     <= x1;
        car1_y     <= y1;
        car1_angle <= a1;
        car2_x     <= x2;
        car2_y     <= y2;
        car2_angle <= a2;
    endtask

    task automatic wait_vsync_fall();
        @(negedge clk);
        while (vsync_n !== 1'b1) begin
            @(negedge clk);
        end
        while (vsync_n !== 1'b0) begin
            @(negedge clk);
        end
    endtask

    // raster position comes from counting valid pixels after vsync
    task automatic compare_frame(input coord_t x1, input coord_t y1, input angle_t a1,
                                 input coord_t x2, input coord_t y2, input angle_t a2);
        int h;
        int v;
        wait_vsync_fall();
        pix_count = 0;
        while (pix_count < FRAME_PIXELS) begin
            @(negedge clk);
            if (rgb_valid === 1'b1) begin
                h = pix_count % `H_ACTIVE;
                v = pix_count / `H_ACTIVE;
                frame_pix[pix_count] = rgb;
                check_rgb($sformatf("o_rgb(%0d,%0d)", h, v), rgb,
                          expected_pixel(h, v, x1, y1, a1, x2, y2, a2));
                pix_count++;
            end
        end
    endtask

    // new inputs are latched at the next frame start, then shown
    task automatic drive_and_compare(input coord_t x1, input coord_t y1, input angle_t a1,
                                     input coord_t x2, input coord_t y2, input angle_t a2);
        wait_vsync_fall();
        drive_cars(x1, y1, a1, x2, y2, a2);
        compare_frame(x1, y1, a1, x2, y2, a2);
    endtask

    task automatic measure_frame_shape();
        int rows;
        int run;
        rows = 0;
        run = 0;
        while (vsync_n !== 1'b1) begin
            @(negedge clk);
        end
        while (vsync_n === 1'b1) begin
            @(negedge clk);
            if (rgb_valid === 1'b1) begin
                run++;
            end else if (run != 0) begin
                expect_count("valid pixels in a row", run, `H_ACTIVE);
                rows++;
                run = 0;
            end
        end
        expect_count("rows per frame", rows, `V_ACTIVE);
    endtask

    task automatic roll_cars();
        for (int i = 0; i < 4; i++) begin
            next_pos[i] = coord_t'(random_word() % 32'd36);
        end
        next_angle[0] = angle_t'(random_word() % 32'd4);
        next_angle[1] = angle_t'(random_word() % 32'd4);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic test_reset_and_timing();
        int lows;
        repeat (3) @(negedge clk);
        check_level("o_hsync_n", hsync_n, 1'b1);
        check_level("o_vsync_n", vsync_n, 1'b1);
        check_level("o_rgb_valid", rgb_valid, 1'b0);
        check_frame_count("o_frame_count", frame_count, '0);
        while (rst_n !== 1'b1) begin
            @(negedge clk);
        end
        lows = 0;
        repeat (2 * `H_TOTAL) begin
            @(negedge clk);
            if (hsync_n === 1'b0) begin
                lows++;
            end
        end
        // 4 of every 40 cycles
        expect_count("hsync low cycles in two lines", lows, 8);
        wait_vsync_fall();
        check_frame_count("o_frame_count", frame_count, 16'd1);
        measure_frame_shape();
        check_frame_count("o_frame_count", frame_count, 16'd2);
    endtask

    task automatic test_background();
        drive_and_compare(6'd50, 6'd0, 2'd0, 6'd50, 6'd0, 2'd0);
    endtask

    task automatic test_single_car();
        drive_and_compare(6'd8, 6'd6, 2'd0, 6'd50, 6'd50, 2'd0);
        check_rgb("o_rgb(9,7)", pixel_at(9, 7), 24'hFF4444);
        check_rgb("o_rgb(8,9)", pixel_at(8, 9), 24'hFFCC00);
        // cut corner of the car
        check_rgb("o_rgb(8,6)", pixel_at(8, 6), BG_ODD);
    endtask

    task automatic test_rotation();
        for (int a = 0; a < 4; a++) begin
            drive_and_compare(6'd20, 6'd12, angle_t'(a), 6'd50, 6'd50, 2'd0);
            if (a == 1) begin
                check_rgb("o_rgb(20,12)", pixel_at(20, 12), 24'hFFCC00);
                check_rgb("o_rgb(23,12)", pixel_at(23, 12), BG_EVEN);
            end
        end
    endtask

    task automatic test_overlap();
        drive_and_compare(6'd10, 6'd10, 2'd0, 6'd12, 6'd10, 2'd0);
        // car1 through the cut corner of car2
        check_rgb("o_rgb(12,10)", pixel_at(12, 10), 24'hFF0088);
        check_rgb("o_rgb(13,10)", pixel_at(13, 10), 24'h330044);
        check_rgb("o_rgb(12,11)", pixel_at(12, 11), 24'h334400);
    endtask

    task automatic test_random_frames();
        coord_t cur_pos [0:3];
        angle_t cur_angle [0:1];
        roll_cars();
        wait_vsync_fall();
        drive_cars(next_pos[0], next_pos[1], next_angle[0],
                   next_pos[2], next_pos[3], next_angle[1]);
        for (int k = 0; k < 8; k++) begin
            cur_pos = next_pos;
            cur_angle = next_angle;
            roll_cars();
            fork
                compare_frame(cur_pos[0], cur_pos[1], cur_angle[0],
                              cur_pos[2], cur_pos[3], cur_angle[1]);
                begin
                    // halfway down the frame being checked
                    wait (pix_count == FRAME_PIXELS / 2);
                    drive_cars(next_pos[0], next_pos[1], next_angle[0],
                               next_pos[2], next_pos[3], next_angle[1]);
                end
            join
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        error_count = 0;
        check_total = 0;
        cycle_count = 0;
        pix_count = 0;
        rng_state = 32'h6d1b_e50a;
        car1_x <= 6'd50;
        car1_y <= 6'd0;
        car2_x <= 6'd50;
        car2_y <= 6'd0;
        car1_angle <= 2'd0;
        car2_angle <= 2'd0;

        test_reset_and_timing();
        test_background();
        test_single_car();
        test_rotation();
        test_overlap();
        test_random_frames();

        $display("checks: %0d, errors: %0d", check_total, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+include
design/video_pkg.sv
design/sprite_pkg.sv
design/sprite_bus_if.sv
design/vga_timing.sv
design/sprite_encoder.sv
design/opacity_mask.sv
design/frame_composer.sv
design/sprite_buffer.sv
design/race_display.sv
dv/tb_clock.sv
dv/tb_race_display.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ns -f project.f \
    --top-module tb_race_display &&
sim_out="$(./obj_dir/Vtb_race_display)" &&
printf '%s\n' "$sim_out" &&
printf '%s\n' "$sim_out" | grep -q "RESULT: PASS" ||
{ echo "simulation failed"; exit 1; }
